// File: project.f
verilog/lce_pkg.sv
verilog/lce_two_fifo.sv
verilog/lce_tag_store.sv
verilog/lce_data_store.sv
verilog/lce_load_align.sv
verilog/lce_ctrl.sv
verilog/lce_top.sv
tests/lce_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mock LCE testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lce_tb -f project.f -Mdir obj_dir -o lce_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lce_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// File: tests/lce_tb.sv
/*
  Testbench for the mock LCE. One trace access is in flight at a time.
  The coherence side is a model with a shadow memory of 48 blocks.
  Inputs change 1 ns after the rising edge; handshakes are sampled at the falling edge.
  Any check failure stops the run at once.
*/
`timescale 1ns/10ps

module lce_tb;

  logic clk_i = 1'b0;
  logic reset_i;
  lce_pkg::trace_req_s trace_req;
  logic trace_req_v, trace_req_ready;
  lce_pkg::trace_resp_s trace_resp;
  logic trace_resp_v, trace_resp_ready;
  lce_pkg::lce_req_s lce_req;
  logic lce_req_v, lce_req_ready;
  lce_pkg::lce_resp_s lce_resp;
  logic lce_resp_v, lce_resp_ready;
  lce_pkg::lce_cmd_s lce_cmd;
  logic lce_cmd_v, lce_cmd_ready;
  lce_pkg::lce_data_cmd_s lce_data_cmd;
  logic lce_data_cmd_v, lce_data_cmd_ready;

  // coherence model state
  lce_pkg::block_t shadow [48];
  int held_blk [16][4];
  lce_pkg::mesi_e held_state [16][4];
  logic held_dirty [16][4];
  lce_pkg::way_t rr_ptr;
  logic [31:0] rng_state;

  lce_pkg::trace_resp_s exp_trace [$];
  lce_pkg::lce_req_s exp_req [$];
  lce_pkg::lce_resp_s exp_resp [$];
  int trace_rd, req_rd, resp_rd;
  logic trace_hold, req_hold, resp_hold;
  lce_pkg::trace_resp_s trace_last;
  lce_pkg::lce_req_s req_last;
  lce_pkg::lce_resp_s resp_last;

  lce_top uut (
    .clk_i(clk_i), .reset_i(reset_i),
    .trace_req_i(trace_req), .trace_req_v_i(trace_req_v), .trace_req_ready_o(trace_req_ready),
    .trace_resp_o(trace_resp), .trace_resp_v_o(trace_resp_v),
    .trace_resp_ready_i(trace_resp_ready),
    .lce_req_o(lce_req), .lce_req_v_o(lce_req_v), .lce_req_ready_i(lce_req_ready),
    .lce_resp_o(lce_resp), .lce_resp_v_o(lce_resp_v), .lce_resp_ready_i(lce_resp_ready),
    .lce_cmd_i(lce_cmd), .lce_cmd_v_i(lce_cmd_v), .lce_cmd_ready_o(lce_cmd_ready),
    .lce_data_cmd_i(lce_data_cmd), .lce_data_cmd_v_i(lce_data_cmd_v),
    .lce_data_cmd_ready_o(lce_data_cmd_ready)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // three tags per set across all sixteen sets
  function automatic lce_pkg::paddr_t block_addr(int b);
    logic [9:0] tag;
    tag = 10'(b / 16 * 37 + 3);
    return {tag, 4'(b % 16), 6'b000000};
  endfunction

  function automatic int find_way(int b);
    int found;
    found = -1;
    for (int w = 0; w < lce_pkg::num_ways; w++) begin
      if (held_blk[b % 16][w] == b) found = w;
    end
    return found;
  endfunction

  // expected load value built byte by byte from the shadow block
  function automatic lce_pkg::dword_t expected_load(lce_pkg::block_t blk, logic [5:0] off,
                                                    lce_pkg::op_size_e size, logic uns);
    lce_pkg::dword_t val;
    int nbytes;
    val = '0;
    nbytes = 1 << int'(size);
    for (int i = 0; i < nbytes; i++) begin
      val[i*8 +: 8] = blk[(int'(off) + i)*8 +: 8];
    end
    if (!uns && nbytes < 8 && val[nbytes*8-1]) begin
      for (int i = nbytes*8; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  task automatic check_trace_resp(lce_pkg::trace_resp_s got, lce_pkg::trace_resp_s exp);
    if (got !== exp) begin
      $display("[FAIL] %0t trace_resp.data got %h expected %h", $time, got.data, exp.data);
      stop_run("trace response mismatch");
    end
  endtask

  task automatic check_req(lce_pkg::lce_req_s got, lce_pkg::lce_req_s exp);
    if (got !== exp) begin
      $display("[FAIL] %0t lce_req got %p expected %p", $time, got, exp);
      stop_run("miss request mismatch");
    end
  endtask

  task automatic check_resp(lce_pkg::lce_resp_s got, lce_pkg::lce_resp_s exp);
    if (got !== exp) begin
      $display("[FAIL] %0t lce_resp got msg=%0d paddr=%h expected msg=%0d paddr=%h",
               $time, got.msg, got.paddr, exp.msg, exp.paddr);
      stop_run("ack mismatch");
    end
  endtask

  // compares every handshake and checks that held outputs stay put
  always @(negedge clk_i) begin
    if (reset_i) begin
      trace_rd = 0;
      req_rd = 0;
      resp_rd = 0;
      trace_hold = 1'b0;
      req_hold = 1'b0;
      resp_hold = 1'b0;
    end else begin
      if (trace_hold && (!trace_resp_v || trace_resp !== trace_last))
        stop_run("trace response changed while waiting for ready");
      if (req_hold && (!lce_req_v || lce_req !== req_last))
        stop_run("miss request changed while waiting for ready");
      if (resp_hold && (!lce_resp_v || lce_resp !== resp_last))
        stop_run("ack changed while waiting for ready");
      if (trace_resp_v && trace_resp_ready) begin
        if (req_rd != exp_req.size()) stop_run("trace response came before its miss request");
        else if (trace_rd >= exp_trace.size()) stop_run("unexpected trace response");
        else check_trace_resp(trace_resp, exp_trace[trace_rd]);
        trace_rd++;
      end
      if (lce_req_v && lce_req_ready) begin
        if (req_rd >= exp_req.size()) stop_run("unexpected miss request");
        else check_req(lce_req, exp_req[req_rd]);
        req_rd++;
      end
      if (lce_resp_v && lce_resp_ready) begin
        if (resp_rd >= exp_resp.size()) stop_run("unexpected ack");
        else check_resp(lce_resp, exp_resp[resp_rd]);
        resp_rd++;
      end
      trace_hold = trace_resp_v && !trace_resp_ready;
      req_hold = lce_req_v && !lce_req_ready;
      resp_hold = lce_resp_v && !lce_resp_ready;
      trace_last = trace_resp;
      req_last = lce_req;
      resp_last = lce_resp;
    end
  end

  task automatic randomize_readies();
    logic [31:0] r;
    r = xorshift32();
    trace_resp_ready = (r[1:0] != 2'b00);
    lce_req_ready = (r[3:2] != 2'b00);
    lce_resp_ready = (r[5:4] != 2'b00);
  endtask

  task automatic run_access();
    logic [31:0] r, r2;
    logic [5:0] off;
    int b, s, hw, nbytes;
    lce_pkg::paddr_t base;
    lce_pkg::trace_req_s req;
    lce_pkg::lce_cmd_s cmd;
    logic accepted, done, tag_first, cmd_pend, dcmd_pend;
    r = xorshift32();
    r2 = xorshift32();
    b = int'(r[31:8] % 24'd48);
    s = b % 16;
    off = r2[5:0] & ~((6'd1 << r[1:0]) - 6'd1);
    base = block_addr(b);
    req.store = (r[6:4] < 3'd3);
    req.is_unsigned = r[2];
    req.size = lce_pkg::op_size_e'(r[1:0]);
    req.paddr = {base[19:6], off};
    req.data = {xorshift32(), xorshift32()};
    hw = find_way(b);
    cmd = '0;
    if (hw < 0 || (req.store && held_state[s][hw] == lce_pkg::e_mesi_s)) begin
      exp_req.push_back('{msg: req.store ? lce_pkg::e_req_write : lce_pkg::e_req_read,
                          paddr: req.paddr,
                          victim_way: (hw >= 0) ? lce_pkg::way_t'(hw) : rr_ptr,
                          victim_dirty: (hw >= 0) ? 1'b0 : held_dirty[s][rr_ptr]});
    end
    exp_trace.push_back(req.store ? '0 : expected_load(shadow[b], off, req.size,
                                                       req.is_unsigned));
    trace_req = req;
    trace_req_v = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = trace_req_ready;
      @(posedge clk_i);
      #1;
    end
    trace_req_v = 1'b0;
    done = 1'b0;
    cmd_pend = 1'b0;
    dcmd_pend = 1'b0;
    tag_first = 1'b0;
    while (!done) begin
      randomize_readies();
      lce_cmd_v = 1'b0;
      lce_data_cmd_v = 1'b0;
      if (cmd_pend && (tag_first || !dcmd_pend)) begin
        lce_cmd = cmd;
        lce_cmd_v = 1'b1;
        cmd_pend = 1'b0;
      end else if (dcmd_pend) begin
        lce_data_cmd = '{way: cmd.way, data: shadow[b]};
        lce_data_cmd_v = 1'b1;
        dcmd_pend = 1'b0;
      end
      @(negedge clk_i);
      if ((lce_cmd_v && !lce_cmd_ready) || (lce_data_cmd_v && !lce_data_cmd_ready))
        stop_run("command buffer not ready while empty");
      if (lce_req_v && lce_req_ready) begin
        r2 = xorshift32();
        cmd.paddr = req.paddr;
        cmd.state = lce_pkg::e_mesi_m;
        cmd_pend = 1'b1;
        if (hw >= 0) begin
          // upgrade of a shared line in place
          cmd.msg = lce_pkg::e_cmd_set_tag_wakeup;
          cmd.way = lce_pkg::way_t'(hw);
        end else begin
          cmd.msg = lce_pkg::e_cmd_set_tag;
          cmd.way = rr_ptr;
          if (!req.store) cmd.state = r2[0] ? lce_pkg::e_mesi_e : lce_pkg::e_mesi_s;
          dcmd_pend = 1'b1;
          tag_first = r2[1];
        end
        exp_resp.push_back('{msg: lce_pkg::e_resp_coh_ack, paddr: req.paddr});
      end
      if (lce_resp_v && lce_resp_ready) begin
        held_blk[s][cmd.way] = b;
        held_state[s][cmd.way] = cmd.state;
        held_dirty[s][cmd.way] = 1'b0;
        if (cmd.msg == lce_pkg::e_cmd_set_tag) rr_ptr = rr_ptr + 2'd1;
      end
      if (trace_resp_v && trace_resp_ready) begin
        done = 1'b1;
        if (req.store) begin
          nbytes = 1 << int'(req.size);
          for (int i = 0; i < nbytes; i++) begin
            shadow[b][(int'(off) + i)*8 +: 8] = req.data[i*8 +: 8];
          end
          hw = find_way(b);
          held_state[s][hw] = lce_pkg::e_mesi_m;
          held_dirty[s][hw] = 1'b1;
        end
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_invalidate();
    logic [31:0] r;
    int s, w;
    logic acked;
    r = xorshift32();
    s = int'(r[3:0]);
    w = int'(r[5:4]);
    if (held_blk[s][w] >= 0) begin
      lce_cmd = '{msg: lce_pkg::e_cmd_invalidate, paddr: block_addr(held_blk[s][w]),
                  way: lce_pkg::way_t'(w), state: lce_pkg::e_mesi_i};
      lce_cmd_v = 1'b1;
      exp_resp.push_back('{msg: lce_pkg::e_resp_inv_ack, paddr: lce_cmd.paddr});
      @(posedge clk_i);
      #1;
      lce_cmd_v = 1'b0;
      acked = 1'b0;
      while (!acked) begin
        randomize_readies();
        @(negedge clk_i);
        acked = lce_resp_v && lce_resp_ready;
        @(posedge clk_i);
        #1;
      end
      held_blk[s][w] = -1;
      held_state[s][w] = lce_pkg::e_mesi_i;
      held_dirty[s][w] = 1'b0;
    end
  endtask

  initial begin
    lce_pkg::paddr_t a;
    logic [31:0] r;
    reset_i = 1'b1;
    trace_req = '0;
    trace_req_v = 1'b0;
    trace_resp_ready = 1'b1;
    lce_req_ready = 1'b1;
    lce_resp_ready = 1'b1;
    lce_cmd = '0;
    lce_cmd_v = 1'b0;
    lce_data_cmd = '0;
    lce_data_cmd_v = 1'b0;
    rng_state = 32'd13976;
    rr_ptr = '0;
    for (int b = 0; b < 48; b++) begin
      for (int i = 0; i < lce_pkg::block_bytes; i++) begin
        a = block_addr(b) + lce_pkg::paddr_t'(i);
        shadow[b][i*8 +: 8] = a[7:0] ^ a[15:8] ^ {a[19:16], a[11:8]};
      end
    end
    for (int s = 0; s < 16; s++) begin
      for (int w = 0; w < 4; w++) begin
        held_blk[s][w] = -1;
        held_state[s][w] = lce_pkg::e_mesi_i;
        held_dirty[s][w] = 1'b0;
      end
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int n = 0; n < 300; n++) begin
      run_access();
      r = xorshift32();
      if (r[1:0] == 2'b00) run_invalidate();
    end
    repeat (4) @(posedge clk_i);
    if (trace_rd != exp_trace.size() || req_rd != exp_req.size() || resp_rd != exp_resp.size())
      stop_run("some expected responses never arrived");
    else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  // budget of 200 cycles per access
  initial begin
    #(300 * 200 * 8);
    stop_run("timeout: the run did not finish in time");
  end

endmodule

// File: verilog/lce_top.sv
/*
  Mock LCE top. Commands and fill data are buffered two deep each.
  All external ports are valid/ready; one trace access is in flight at a time.
*/
`timescale 1ns/10ps

module lce_top (
  input  logic clk_i,
  input  logic reset_i,
  input  lce_pkg::trace_req_s trace_req_i,
  input  logic trace_req_v_i,
  output logic trace_req_ready_o,
  output lce_pkg::trace_resp_s trace_resp_o,
  output logic trace_resp_v_o,
  input  logic trace_resp_ready_i,
  output lce_pkg::lce_req_s lce_req_o,
  output logic lce_req_v_o,
  input  logic lce_req_ready_i,
  output lce_pkg::lce_resp_s lce_resp_o,
  output logic lce_resp_v_o,
  input  logic lce_resp_ready_i,
  input  lce_pkg::lce_cmd_s lce_cmd_i,
  input  logic lce_cmd_v_i,
  output logic lce_cmd_ready_o,
  input  lce_pkg::lce_data_cmd_s lce_data_cmd_i,
  input  logic lce_data_cmd_v_i,
  output logic lce_data_cmd_ready_o
);

  lce_pkg::lce_cmd_s cmd;
  lce_pkg::lce_data_cmd_s dcmd;
  logic cmd_v, cmd_yumi, dcmd_v, dcmd_yumi;
  lce_pkg::index_t tag_index, data_index;
  lce_pkg::ptag_t tag_ptag;
  lce_pkg::way_t victim_way, tag_w_way, hit_way, data_way;
  logic tag_w, hit, victim_dirty, fill, store;
  lce_pkg::tag_entry_s tag_w_entry;
  lce_pkg::mesi_e hit_state;
  lce_pkg::block_t fill_data, block;
  lce_pkg::trace_req_s cur_req;
  lce_pkg::dword_t load_dword;

  lce_two_fifo #(.width_p($bits(lce_pkg::lce_cmd_s))) cmd_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(lce_cmd_i), .v_i(lce_cmd_v_i), .ready_o(lce_cmd_ready_o),
    .data_o(cmd), .v_o(cmd_v), .yumi_i(cmd_yumi)
  );

  lce_two_fifo #(.width_p($bits(lce_pkg::lce_data_cmd_s))) dcmd_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(lce_data_cmd_i), .v_i(lce_data_cmd_v_i), .ready_o(lce_data_cmd_ready_o),
    .data_o(dcmd), .v_o(dcmd_v), .yumi_i(dcmd_yumi)
  );

  lce_tag_store tag_store (
    .clk_i(clk_i), .reset_i(reset_i),
    .index_i(tag_index), .ptag_i(tag_ptag), .victim_way_i(victim_way),
    .w_i(tag_w), .w_way_i(tag_w_way), .w_entry_i(tag_w_entry),
    .hit_o(hit), .hit_way_o(hit_way), .hit_state_o(hit_state),
    .victim_dirty_o(victim_dirty)
  );

  lce_data_store data_store (
    .clk_i(clk_i), .index_i(data_index), .way_i(data_way),
    .fill_i(fill), .fill_data_i(fill_data),
    .store_i(store), .store_dword_i(cur_req.data),
    .store_offset_i(cur_req.paddr[lce_pkg::offset_bits-1:0]), .store_size_i(cur_req.size),
    .block_o(block)
  );

  lce_load_align load_align (
    .block_i(block), .offset_i(cur_req.paddr[lce_pkg::offset_bits-1:0]),
    .size_i(cur_req.size), .unsigned_i(cur_req.is_unsigned), .data_o(load_dword)
  );

  lce_ctrl ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .trace_req_i(trace_req_i), .trace_req_v_i(trace_req_v_i),
    .trace_req_ready_o(trace_req_ready_o),
    .trace_resp_o(trace_resp_o), .trace_resp_v_o(trace_resp_v_o),
    .trace_resp_ready_i(trace_resp_ready_i),
    .lce_req_o(lce_req_o), .lce_req_v_o(lce_req_v_o), .lce_req_ready_i(lce_req_ready_i),
    .lce_resp_o(lce_resp_o), .lce_resp_v_o(lce_resp_v_o), .lce_resp_ready_i(lce_resp_ready_i),
    .cmd_i(cmd), .cmd_v_i(cmd_v), .cmd_yumi_o(cmd_yumi),
    .dcmd_i(dcmd), .dcmd_v_i(dcmd_v), .dcmd_yumi_o(dcmd_yumi),
    .tag_index_o(tag_index), .tag_ptag_o(tag_ptag), .victim_way_o(victim_way),
    .tag_w_o(tag_w), .tag_w_way_o(tag_w_way), .tag_w_entry_o(tag_w_entry),
    .hit_i(hit), .hit_way_i(hit_way), .hit_state_i(hit_state),
    .victim_dirty_i(victim_dirty),
    .data_index_o(data_index), .data_way_o(data_way),
    .fill_o(fill), .fill_data_o(fill_data), .store_o(store),
    .cur_req_o(cur_req), .load_dword_i(load_dword)
  );

endmodule

// File: verilog/lce_ctrl.sv
/*
  Controller FSM. One trace access at a time; a miss is always replayed to a hit.
  Invalidates are taken only in idle. Tag writes from the coherence side are applied
  when their ack is accepted. The victim pointer advances after each set_tag fill.
*/
`timescale 1ns/10ps

module lce_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  lce_pkg::trace_req_s trace_req_i,
  input  logic trace_req_v_i,
  output logic trace_req_ready_o,
  output lce_pkg::trace_resp_s trace_resp_o,
  output logic trace_resp_v_o,
  input  logic trace_resp_ready_i,
  output lce_pkg::lce_req_s lce_req_o,
  output logic lce_req_v_o,
  input  logic lce_req_ready_i,
  output lce_pkg::lce_resp_s lce_resp_o,
  output logic lce_resp_v_o,
  input  logic lce_resp_ready_i,
  input  lce_pkg::lce_cmd_s cmd_i,
  input  logic cmd_v_i,
  output logic cmd_yumi_o,
  input  lce_pkg::lce_data_cmd_s dcmd_i,
  input  logic dcmd_v_i,
  output logic dcmd_yumi_o,
  output lce_pkg::index_t tag_index_o,
  output lce_pkg::ptag_t tag_ptag_o,
  output lce_pkg::way_t victim_way_o,
  output logic tag_w_o,
  output lce_pkg::way_t tag_w_way_o,
  output lce_pkg::tag_entry_s tag_w_entry_o,
  input  logic hit_i,
  input  lce_pkg::way_t hit_way_i,
  input  lce_pkg::mesi_e hit_state_i,
  input  logic victim_dirty_i,
  output lce_pkg::index_t data_index_o,
  output lce_pkg::way_t data_way_o,
  output logic fill_o,
  output lce_pkg::block_t fill_data_o,
  output logic store_o,
  output lce_pkg::trace_req_s cur_req_o,
  input  lce_pkg::dword_t load_dword_i
);

  lce_pkg::ctrl_state_e state_r;
  lce_pkg::trace_req_s req_r;
  lce_pkg::lce_cmd_s cmd_r;
  lce_pkg::lce_resp_s ack_r;
  lce_pkg::way_t victim_r, dway_r;
  logic tag_recv_r, data_recv_r, ack_v_r;
  logic in_lookup, writable, acc_hit;
  logic trace_go, resp_go, req_go, ack_go, ack_set;

  assign in_lookup = (state_r == lce_pkg::e_lookup) || (state_r == lce_pkg::e_replay);
  assign writable = hit_state_i inside {lce_pkg::e_mesi_e, lce_pkg::e_mesi_m};
  assign acc_hit = hit_i && (!req_r.store || writable);

  assign trace_req_ready_o = (state_r == lce_pkg::e_idle) && !ack_v_r && !cmd_v_i && !dcmd_v_i;
  assign trace_resp_v_o = in_lookup && acc_hit;
  assign trace_resp_o = req_r.store ? '0 : load_dword_i;

  // a hit that is not writable is a store to S, upgraded in place
  assign lce_req_v_o = in_lookup && !acc_hit;
  assign lce_req_o = '{
    msg: req_r.store ? lce_pkg::e_req_write : lce_pkg::e_req_read,
    paddr: req_r.paddr,
    victim_way: hit_i ? hit_way_i : victim_r,
    victim_dirty: hit_i ? 1'b0 : victim_dirty_i
  };

  assign lce_resp_v_o = ack_v_r;
  assign lce_resp_o = ack_r;

  assign trace_go = trace_req_v_i && trace_req_ready_o;
  assign resp_go = trace_resp_v_o && trace_resp_ready_i;
  assign req_go = lce_req_v_o && lce_req_ready_i;
  assign ack_go = ack_v_r && lce_resp_ready_i;

  always_comb begin
    cmd_yumi_o = 1'b0;
    dcmd_yumi_o = 1'b0;
    if (!ack_v_r && cmd_v_i) begin
      if (state_r == lce_pkg::e_idle) begin
        cmd_yumi_o = (cmd_i.msg == lce_pkg::e_cmd_invalidate);
      end else if (state_r == lce_pkg::e_miss_wait) begin
        cmd_yumi_o = (cmd_i.msg == lce_pkg::e_cmd_set_tag_wakeup)
                  || (cmd_i.msg == lce_pkg::e_cmd_set_tag && !tag_recv_r);
      end
    end
    if (state_r == lce_pkg::e_miss_wait && !ack_v_r && !cmd_yumi_o && dcmd_v_i && !data_recv_r) begin
      dcmd_yumi_o = 1'b1;
    end
  end

  // fill ack waits for the second half of the tag/data pair
  assign ack_set = (cmd_yumi_o && (cmd_i.msg != lce_pkg::e_cmd_set_tag || data_recv_r))
                || (dcmd_yumi_o && tag_recv_r);

  assign tag_index_o = ack_v_r ? cmd_r.paddr[lce_pkg::offset_bits +: lce_pkg::index_bits]
                               : req_r.paddr[lce_pkg::offset_bits +: lce_pkg::index_bits];
  assign tag_ptag_o = req_r.paddr[lce_pkg::paddr_bits-1 -: lce_pkg::ptag_bits];
  assign victim_way_o = victim_r;
  assign tag_w_o = ack_go || (store_o && hit_state_i == lce_pkg::e_mesi_e);

  always_comb begin
    if (ack_v_r) begin
      tag_w_way_o = cmd_r.way;
      tag_w_entry_o.ptag = cmd_r.paddr[lce_pkg::paddr_bits-1 -: lce_pkg::ptag_bits];
      tag_w_entry_o.state = (cmd_r.msg == lce_pkg::e_cmd_invalidate) ? lce_pkg::e_mesi_i
                                                                       : cmd_r.state;
    end else begin
      // E to M upgrade on a store hit
      tag_w_way_o = hit_way_i;
      tag_w_entry_o.ptag = tag_ptag_o;
      tag_w_entry_o.state = lce_pkg::e_mesi_m;
    end
  end

  assign data_index_o = req_r.paddr[lce_pkg::offset_bits +: lce_pkg::index_bits];
  assign data_way_o = dcmd_yumi_o ? dcmd_i.way : hit_way_i;
  assign fill_o = dcmd_yumi_o;
  assign fill_data_o = dcmd_i.data;
  assign store_o = resp_go && req_r.store;
  assign cur_req_o = req_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= lce_pkg::e_idle;
      victim_r <= '0;
      tag_recv_r <= 1'b0;
      data_recv_r <= 1'b0;
      ack_v_r <= 1'b0;
    end else begin
      case (state_r)
        lce_pkg::e_idle: if (trace_go) state_r <= lce_pkg::e_lookup;
        lce_pkg::e_lookup, lce_pkg::e_replay: begin
          if (resp_go) state_r <= lce_pkg::e_idle;
          else if (req_go) state_r <= lce_pkg::e_miss_wait;
        end
        lce_pkg::e_miss_wait: if (ack_go) state_r <= lce_pkg::e_replay;
        default: state_r <= lce_pkg::e_idle;
      endcase
      if (req_go) begin
        tag_recv_r <= 1'b0;
        data_recv_r <= 1'b0;
      end
      if (cmd_yumi_o && cmd_i.msg == lce_pkg::e_cmd_set_tag) tag_recv_r <= 1'b1;
      if (dcmd_yumi_o) data_recv_r <= 1'b1;
      if (ack_set) ack_v_r <= 1'b1;
      else if (ack_go) ack_v_r <= 1'b0;
      if (ack_go && cmd_r.msg == lce_pkg::e_cmd_set_tag) victim_r <= victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (trace_go) req_r <= trace_req_i;
    if (cmd_yumi_o) cmd_r <= cmd_i;
    if (dcmd_yumi_o) dway_r <= dcmd_i.way;
    if (ack_set) begin
      ack_r.msg <= (cmd_yumi_o && cmd_i.msg == lce_pkg::e_cmd_invalidate)
                 ? lce_pkg::e_resp_inv_ack : lce_pkg::e_resp_coh_ack;
      ack_r.paddr <= cmd_yumi_o ? cmd_i.paddr : req_r.paddr;
    end
  end

  // fill data must land in the way named by its set_tag
  a_fill_way: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_v_r && cmd_r.msg == lce_pkg::e_cmd_set_tag) |-> (dway_r == cmd_r.way));

endmodule

// File: verilog/lce_load_align.sv
/*
  Load data path. Picks the dword, shifts the field down and extends it.
  Accesses are assumed naturally aligned.
*/
`timescale 1ns/10ps

module lce_load_align (
  input  lce_pkg::block_t block_i,
  input  logic [lce_pkg::offset_bits-1:0] offset_i,
  input  lce_pkg::op_size_e size_i,
  input  logic unsigned_i,
  output lce_pkg::dword_t data_o
);

  lce_pkg::dword_t dw, shifted;
  logic [2:0] lane;

  always_comb begin
    dw = block_i[offset_i[lce_pkg::offset_bits-1:3]*lce_pkg::dword_bits +: lce_pkg::dword_bits];
    lane = offset_i[2:0] & ~((3'd1 << size_i) - 3'd1);
    shifted = dw >> {lane, 3'b000};
    case (size_i)
      lce_pkg::e_size_byte: data_o = {{56{~unsigned_i & shifted[7]}}, shifted[7:0]};
      lce_pkg::e_size_half: data_o = {{48{~unsigned_i & shifted[15]}}, shifted[15:0]};
      lce_pkg::e_size_word: data_o = {{32{~unsigned_i & shifted[31]}}, shifted[31:0]};
      default: data_o = shifted;
    endcase
  end

endmodule

// File: verilog/lce_data_store.sv
/*
  Block data array, no reset. Reads are combinational.
  A fill writes the whole block and wins over a store in the same cycle.
  Stores are assumed naturally aligned; low offset bits below the size are ignored.
*/
`timescale 1ns/10ps

module lce_data_store (
  input  logic clk_i,
  input  lce_pkg::index_t index_i,
  input  lce_pkg::way_t way_i,
  input  logic fill_i,
  input  lce_pkg::block_t fill_data_i,
  input  logic store_i,
  input  lce_pkg::dword_t store_dword_i,
  input  logic [lce_pkg::offset_bits-1:0] store_offset_i,
  input  lce_pkg::op_size_e store_size_i,
  output lce_pkg::block_t block_o
);

  lce_pkg::block_t blocks_r [lce_pkg::num_sets][lce_pkg::num_ways];
  logic [lce_pkg::offset_bits-1:0] offset_al;
  lce_pkg::byte_mask_t mask;
  lce_pkg::block_t wdata;

  assign block_o = blocks_r[index_i][way_i];

  always_comb begin
    offset_al = store_offset_i & ~((6'd1 << store_size_i) - 6'd1);
    // 1, 2, 4 or 8 enabled bytes at the aligned offset
    mask = ((lce_pkg::byte_mask_t'(1) << (4'd1 << store_size_i)) - lce_pkg::byte_mask_t'(1))
           << offset_al;
    wdata = lce_pkg::block_t'(store_dword_i) << {offset_al, 3'b000};
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      blocks_r[index_i][way_i] <= fill_data_i;
    end else if (store_i) begin
      for (int b = 0; b < lce_pkg::block_bytes; b++) begin
        if (mask[b]) blocks_r[index_i][way_i][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

endmodule

// File: verilog/lce_tag_store.sv
/*
  Tag and MESI state per set and way. Lookup is combinational.
  Reset invalidates every way. A write lands at the next edge.
*/
`timescale 1ns/10ps

module lce_tag_store (
  input  logic clk_i,
  input  logic reset_i,
  input  lce_pkg::index_t index_i,
  input  lce_pkg::ptag_t ptag_i,
  input  lce_pkg::way_t victim_way_i,
  input  logic w_i,
  input  lce_pkg::way_t w_way_i,
  input  lce_pkg::tag_entry_s w_entry_i,
  output logic hit_o,
  output lce_pkg::way_t hit_way_o,
  output lce_pkg::mesi_e hit_state_o,
  output logic victim_dirty_o
);

  lce_pkg::tag_entry_s [lce_pkg::num_sets-1:0][lce_pkg::num_ways-1:0] tags_r;
  lce_pkg::tag_entry_s [lce_pkg::num_ways-1:0] set_rd;
  logic [lce_pkg::num_ways-1:0] hits;

  assign set_rd = tags_r[index_i];

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < lce_pkg::num_ways; w++) begin
      hits[w] = (set_rd[w].state != lce_pkg::e_mesi_i) && (set_rd[w].ptag == ptag_i);
      if (hits[w]) hit_way_o = lce_pkg::way_t'(w);
    end
  end

  assign hit_o = |hits;
  assign hit_state_o = set_rd[hit_way_o].state;
  assign victim_dirty_o = (set_rd[victim_way_i].state == lce_pkg::e_mesi_m);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tags_r <= '0;
    end else if (w_i) begin
      tags_r[index_i][w_way_i] <= w_entry_i;
    end
  end

  // fills and invalidates from the coherence side must never alias a tag
  a_one_hit: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hits));

endmodule

// File: verilog/lce_two_fifo.sv
/*
  Two-entry valid/ready buffer. Output is valid the cycle after a push.
  yumi_i dequeues the head and must only be raised while v_o is high.
*/
`timescale 1ns/10ps

module lce_two_fifo #(
  parameter int width_p = 8
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [width_p-1:0] data_i,
  input  logic v_i,
  output logic ready_o,
  output logic [width_p-1:0] data_o,
  output logic v_o,
  input  logic yumi_i
);

  logic [width_p-1:0] mem_r [2];
  logic rptr_r, wptr_r;
  logic [1:0] count_r;
  logic push, pop;

  assign ready_o = (count_r != 2'd2);
  assign v_o = (count_r != 2'd0);
  assign data_o = mem_r[rptr_r];
  assign push = v_i && ready_o;
  assign pop = yumi_i && v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r <= 1'b0;
      wptr_r <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (push) wptr_r <= ~wptr_r;
      if (pop) rptr_r <= ~rptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wptr_r] <= data_i;
  end

  // consumer must never dequeue an empty buffer
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

// File: verilog/lce_pkg.sv
/*
  Shared geometry, types and message formats for the mock LCE.
  Physical address split is {ptag, index, offset}. Blocks are 64 bytes.
  MESI state I encodes as zero, so a cleared tag entry is invalid.
*/
package lce_pkg;

  localparam int num_sets = 16;
  localparam int num_ways = 4;
  localparam int block_bytes = 64;
  localparam int paddr_bits = 20;
  localparam int dword_bits = 64;
  localparam int offset_bits = 6;
  localparam int index_bits = 4;
  localparam int ptag_bits = 10;
  localparam int way_bits = 2;

  typedef logic [paddr_bits-1:0] paddr_t;
  typedef logic [ptag_bits-1:0] ptag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [way_bits-1:0] way_t;
  typedef logic [dword_bits-1:0] dword_t;
  typedef logic [block_bytes*8-1:0] block_t;
  typedef logic [block_bytes-1:0] byte_mask_t;

  typedef enum logic [1:0] {e_mesi_i, e_mesi_s, e_mesi_e, e_mesi_m} mesi_e;
  typedef enum logic [1:0] {e_size_byte, e_size_half, e_size_word, e_size_double} op_size_e;
  typedef enum logic {e_req_read, e_req_write} req_msg_e;
  typedef enum logic [1:0] {e_cmd_set_tag, e_cmd_set_tag_wakeup, e_cmd_invalidate} cmd_msg_e;
  typedef enum logic {e_resp_coh_ack, e_resp_inv_ack} resp_msg_e;
  typedef enum logic [1:0] {e_idle, e_lookup, e_miss_wait, e_replay} ctrl_state_e;

  typedef struct packed {
    logic store;
    logic is_unsigned;
    op_size_e size;
    paddr_t paddr;
    dword_t data;
  } trace_req_s;

  typedef struct packed {
    dword_t data;
  } trace_resp_s;

  typedef struct packed {
    req_msg_e msg;
    paddr_t paddr;
    way_t victim_way;
    logic victim_dirty;
  } lce_req_s;

  typedef struct packed {
    cmd_msg_e msg;
    paddr_t paddr;
    way_t way;
    mesi_e state;
  } lce_cmd_s;

  typedef struct packed {
    way_t way;
    block_t data;
  } lce_data_cmd_s;

  typedef struct packed {
    resp_msg_e msg;
    paddr_t paddr;
  } lce_resp_s;

  typedef struct packed {
    mesi_e state;
    ptag_t ptag;
  } tag_entry_s;

endpackage
